// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= l3_top_tb
RTL_TOP   ?= l3_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/l3_top_chk.sv ====
/*
  L3 cache handshake checker
  Bound to the top level, checks that held commands stay stable
*/
`default_nettype none

module l3_top_chk (
  input logic                                 clk,
  input logic                                 reset,
  input logic                                 rsp_valid,
  input l3_cache_pkg::l3_rsp_t                rsp,
  input logic                                 rsp_ready,
  input logic                                 mem_req_valid,
  input l3_cache_pkg::mem_req_t               mem_req,
  input logic                                 mem_req_ready,
  input logic [l3_cache_pkg::NUM_PORTS-1:0]   port_ready,
  input logic                                 arb_valid,
  input logic                                 arb_ready
);

  import l3_cache_pkg::*;

  // Response held until taken
  rsp_stable: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("rsp changed while waiting for rsp_ready");

  mem_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else $error("mem_req changed while waiting for mem_req_ready");

  // Full arbiter register blocks all ports
  no_grant_when_full: assert property (@(posedge clk) disable iff (reset)
    arb_valid && !arb_ready |-> port_ready == '0)
    else $error("port_ready high while the arbiter register is held");

endmodule

bind l3_top l3_top_chk chk_i (
  .clk           (clk),
  .reset         (reset),
  .rsp_valid     (rsp_valid),
  .rsp           (rsp),
  .rsp_ready     (rsp_ready),
  .mem_req_valid (mem_req_valid),
  .mem_req       (mem_req),
  .mem_req_ready (mem_req_ready),
  .port_ready    (port_ready),
  .arb_valid     (arb_valid),
  .arb_ready     (arb_ready)
);

`default_nettype wire

// ==== bench/l3_top_tb.sv ====
/*
  L3 cache testbench
  Memory model, stimulus table with a reference model, four port contention
*/
`default_nettype none

module l3_top_tb;

  import l3_cache_pkg::*;

  typedef struct {
    int                port;
    bit                write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    bit                stall;
    int                mem_cmds;  // Memory commands this access should cause
  } stim_t;

  localparam int NUM_STIM    = 8;
  localparam int CYCLE_LIMIT = (2 * NUM_STIM + 2 * NUM_PORTS) * 40 + 32;
  localparam logic [DATA_W-1:0] MEM_PATTERN = 32'hDEAD_BEEF;

  logic              clk = 1'b0;
  logic              reset;
  logic [NUM_PORTS-1:0] port_valid;
  l3_req_t           port_req [NUM_PORTS];
  logic [NUM_PORTS-1:0] port_ready;
  logic              rsp_valid;
  l3_rsp_t           rsp;
  logic              rsp_ready;
  logic              mem_req_valid;
  mem_req_t          mem_req;
  logic              mem_req_ready;
  logic              mem_rsp_valid;
  logic [DATA_W-1:0] mem_rsp_data;

  stim_t             stim [NUM_STIM];
  logic [DATA_W-1:0] mem_words [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] ref_words [logic [ADDR_W-1:0]];
  mem_req_t          mem_log [$];
  logic [ADDR_W-1:0] read_addr;
  int                read_wait;   // Cycles left until the read data, 0 when none pending
  bit                stall_on;
  int                cycles;

  l3_top l3_top_i (.*);

  always #50 clk = ~clk;

  function automatic logic [DATA_W-1:0] expected_word(logic [ADDR_W-1:0] addr);
    return ref_words.exists(addr) ? ref_words[addr] : (DATA_W'(addr) ^ MEM_PATTERN);
  endfunction

  task automatic check(string name, logic [DATA_W-1:0] expected, logic [DATA_W-1:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_with(string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Main memory: accepts at posedge, answers reads after a random delay
  always @(posedge clk) begin
    if (!reset && mem_req_valid && mem_req_ready) begin
      mem_log.push_back(mem_req);
      if (mem_req.write) begin
        mem_words[mem_req.addr] = mem_req.data;
      end else begin
        read_addr = mem_req.addr;
        read_wait = 1 + int'($urandom % 4);
      end
    end
  end

  always @(negedge clk) begin
    mem_req_ready = stall_on ? 1'($urandom % 2) : 1'b1;
    rsp_ready     = stall_on ? 1'($urandom % 2) : 1'b1;
    mem_rsp_valid = 1'b0;
    if (read_wait > 0) begin
      read_wait--;
      if (read_wait == 0) begin
        mem_rsp_valid = 1'b1;
        mem_rsp_data  = mem_words.exists(read_addr) ? mem_words[read_addr]
                                                    : (DATA_W'(read_addr) ^ MEM_PATTERN);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      fail_with("Timeout: the DUT stopped making progress");
    end
  end

  task automatic apply_reset();
    reset = 1'b1;
    mem_words.delete();
    ref_words.delete();
    read_wait = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_entry(int i, bit stall_all);
    stim_t s;
    string name;
    int    latency;   // Cycles from port handshake to response
    s    = stim[i];
    name = $sformatf("entry%0d", i);
    @(negedge clk);
    stall_on = stall_all || s.stall;
    mem_log.delete();
    port_req[s.port]   = '{write: s.write, addr: s.addr, wdata: s.wdata, port: '0};
    port_valid[s.port] = 1'b1;
    do @(posedge clk); while (!port_ready[s.port]);
    @(negedge clk);
    port_valid[s.port] = 1'b0;
    latency = 0;
    do begin
      @(posedge clk);
      latency++;
    end while (!(rsp_valid && rsp_ready));
    if (!stall_on && s.mem_cmds == 0) begin
      check({name, "_latency"}, 2, latency);  // Hit: arbiter register, then lookup
    end
    check({name, "_port"}, DATA_W'(s.port), DATA_W'(rsp.port));
    check({name, "_write"}, DATA_W'(s.write), DATA_W'(rsp.write));
    check({name, "_data"}, s.write ? s.wdata : expected_word(s.addr), rsp.data);
    check({name, "_mem_cmds"}, DATA_W'(s.mem_cmds), DATA_W'(mem_log.size()));
    foreach (mem_log[k]) begin
      if (mem_log[k].write) begin
        check({name, "_wb_data"}, expected_word(mem_log[k].addr), mem_log[k].data);
        check({name, "_wb_first"}, 0, k);  // Write-back goes before the read
      end else begin
        check({name, "_read_addr"}, DATA_W'(s.addr), DATA_W'(mem_log[k].addr));
      end
    end
    if (s.write) begin
      ref_words[s.addr] = s.wdata;
    end
  endtask

  // All four ports raise a read in the same cycle, each asks twice
  task automatic run_all_ports();
    int                   grants  [NUM_PORTS];
    int                   answers [NUM_PORTS];
    logic [NUM_PORTS-1:0] served;   // Ports granted in the current round
    int                   total;
    served = '0;
    total  = 0;
    @(negedge clk);
    stall_on = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      grants[p]   = 0;
      answers[p]  = 0;
      port_req[p] = '{write: 1'b0, addr: 16'h0065 + ADDR_W'(p), wdata: '0, port: '0};
    end
    port_valid = '1;
    while (total < 2 * NUM_PORTS) begin
      @(posedge clk);
      if (rsp_valid && rsp_ready) begin
        if (answers[rsp.port] == 2) begin
          fail_with("A port got more responses than it asked for");
        end
        check("all_ports_write", 0, DATA_W'(rsp.write));
        check("all_ports_data", expected_word(16'h0065 + ADDR_W'(rsp.port)), rsp.data);
        answers[rsp.port]++;
        total++;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port_valid[p] && port_ready[p]) begin
          if (served[p] && ((port_valid & ~served) != '0)) begin
            fail_with("A port was served twice while another port waited");
          end
          if (served[p]) begin
            served = '0;  // Every waiting port had its turn
          end
          served[p] = 1'b1;
          grants[p]++;
        end
      end
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (grants[p] == 2) begin
          port_valid[p] = 1'b0;
        end
      end
    end
  endtask

  initial begin
    void'($urandom(52));
    cycles        = 0;
    stall_on      = 1'b0;
    port_valid    = '0;
    rsp_ready     = 1'b1;
    mem_req_ready = 1'b1;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    read_addr     = '0;
    foreach (port_req[p]) port_req[p] = '0;
    stim = '{
      '{0, 1'b0, 16'h0012, 32'h0,         1'b0, 1},  // Fresh read miss
      '{1, 1'b1, 16'h0023, 32'hA5A5_0001, 1'b0, 1},
      '{2, 1'b0, 16'h0023, 32'h0,         1'b0, 0},  // Hit on the written word
      '{3, 1'b1, 16'h0034, 32'h1234_5678, 1'b0, 1},
      '{0, 1'b0, 16'h1034, 32'h0,         1'b0, 2},  // Evicts dirty 0x0034
      '{1, 1'b0, 16'h0034, 32'h0,         1'b0, 1},
      '{2, 1'b1, 16'h0012, 32'hCAFE_0042, 1'b1, 0},
      '{3, 1'b0, 16'h0012, 32'h0,         1'b1, 0}
    };
    apply_reset();
    for (int i = 0; i < NUM_STIM; i++) run_entry(i, 1'b0);
    apply_reset();
    for (int i = 0; i < NUM_STIM; i++) run_entry(i, 1'b1);
    run_all_ports();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/l3_cache_pkg.sv ====
/*
  L3 cache shared definitions
  Address split, word width and the request, response and memory command structs
*/
`default_nettype none

package l3_cache_pkg;

  // Requester side
  localparam int NUM_PORTS = 4;
  localparam int PORT_W    = 2;

  // Word addressed, one word per line
  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 32;
  localparam int INDEX_W  = 4;
  localparam int NUM_SETS = 16;
  localparam int TAG_W    = ADDR_W - INDEX_W;

  // Request from an L2 port, port field stamped by the arbiter
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [PORT_W-1:0] port;
  } l3_req_t;

  // Response back to the requesting port
  typedef struct packed {
    logic [PORT_W-1:0] port;
    logic              write;
    logic [DATA_W-1:0] data; // Read word or echoed write word
  } l3_rsp_t;

  // Main memory command
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== hw/l3_cache/l3_line_fill.sv ====
/*
  L3 line fill
  Writes back a dirty victim, then reads the missing word from main memory
*/
`default_nettype none

module l3_line_fill (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               fill_valid,
  input  logic                               fill_victim_dirty,
  input  logic [l3_cache_pkg::ADDR_W-1:0]    fill_victim_addr,
  input  logic [l3_cache_pkg::DATA_W-1:0]    fill_victim_data,
  input  logic [l3_cache_pkg::ADDR_W-1:0]    fill_addr,
  output logic                               fill_ready,
  output logic                               fill_done,
  output logic [l3_cache_pkg::DATA_W-1:0]    fill_data,
  output logic                               mem_req_valid,
  output l3_cache_pkg::mem_req_t             mem_req,
  input  logic                               mem_req_ready,
  input  logic                               mem_rsp_valid,
  input  logic [l3_cache_pkg::DATA_W-1:0]    mem_rsp_data
);

  import l3_cache_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BACK,
    READ_REQ,
    READ_WAIT
  } state_t;

  state_t state, next_state;

  logic [ADDR_W-1:0] victim_addr_q;
  logic [DATA_W-1:0] victim_data_q;
  logic [ADDR_W-1:0] line_addr_q;   // Word to bring in
  logic              start;
  logic              write_back;

  assign fill_ready = (state == IDLE);
  assign start      = fill_valid && fill_ready;
  assign write_back = (state == WRITE_BACK);

  // Command is built from registers only, so it holds while stalled
  always_comb begin
    mem_req_valid = write_back || (state == READ_REQ);
    mem_req.write = write_back;
    mem_req.addr  = write_back ? victim_addr_q : line_addr_q;
    mem_req.data  = write_back ? victim_data_q : '0;
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (start) begin
          next_state = fill_victim_dirty ? WRITE_BACK : READ_REQ; // Clean victim skips write
        end
      end
      WRITE_BACK: begin
        if (mem_req_ready) begin
          next_state = READ_REQ;
        end
      end
      READ_REQ: begin
        if (mem_req_ready) begin
          next_state = READ_WAIT;
        end
      end
      READ_WAIT: begin
        if (mem_rsp_valid) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      fill_done <= 1'b0;
    end else begin
      state     <= next_state;
      fill_done <= (state == READ_WAIT) && mem_rsp_valid; // One cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      victim_addr_q <= fill_victim_addr;
      victim_data_q <= fill_victim_data;
      line_addr_q   <= fill_addr;
    end
    if ((state == READ_WAIT) && mem_rsp_valid) begin
      fill_data <= mem_rsp_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/l3_cache/l3_lookup.sv ====
/*
  L3 lookup stage
  Direct-mapped tag, valid, dirty and data arrays with hit check and write update.
  Misses hand the victim to the line fill and retry once the new line is in.
*/
`default_nettype none

module l3_lookup (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               arb_valid,
  input  l3_cache_pkg::l3_req_t              arb_req,
  output logic                               arb_ready,
  output logic                               fill_valid,
  input  logic                               fill_ready,
  output logic                               fill_victim_dirty,
  output logic [l3_cache_pkg::ADDR_W-1:0]    fill_victim_addr,
  output logic [l3_cache_pkg::DATA_W-1:0]    fill_victim_data,
  output logic [l3_cache_pkg::ADDR_W-1:0]    fill_addr,
  input  logic                               fill_done,
  input  logic [l3_cache_pkg::DATA_W-1:0]    fill_data,
  output logic                               rsp_valid,
  output l3_cache_pkg::l3_rsp_t              rsp,
  input  logic                               rsp_ready
);

  import l3_cache_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    COMPARE,   // Check the held request
    WAIT_FILL,
    RESPOND
  } state_t;

  state_t state, next_state;

  logic [TAG_W-1:0]    tag_q  [NUM_SETS];
  logic [DATA_W-1:0]   data_q [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;

  l3_req_t          req_q;   // Request being worked on
  l3_req_t          cur_req;
  logic [INDEX_W-1:0] cur_index;
  logic [TAG_W-1:0]   cur_tag;
  logic             accept;
  logic             lookup_en;
  logic             hit;
  logic             fill_load;

  assign arb_ready = (state == IDLE);
  assign accept    = arb_valid && arb_ready;

  // Fresh request in idle, held one otherwise
  assign cur_req   = (state == IDLE) ? arb_req : req_q;
  assign cur_index = cur_req.addr[INDEX_W-1:0];
  assign cur_tag   = cur_req.addr[ADDR_W-1:INDEX_W];

  assign lookup_en = accept || (state == COMPARE);
  assign hit       = lookup_en && valid_q[cur_index] && (tag_q[cur_index] == cur_tag);
  assign fill_load = (state == WAIT_FILL) && fill_done;

  // Victim is whatever sits in the line now
  assign fill_valid        = (state == COMPARE) && !hit;
  assign fill_victim_dirty = valid_q[cur_index] && dirty_q[cur_index];
  assign fill_victim_addr  = {tag_q[cur_index], cur_index};
  assign fill_victim_data  = data_q[cur_index];
  assign fill_addr         = req_q.addr;

  assign rsp_valid = (state == RESPOND);

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (accept) begin
          next_state = hit ? RESPOND : COMPARE;
        end
      end
      COMPARE: begin
        if (hit) begin
          next_state = RESPOND;
        end else if (fill_ready) begin
          next_state = WAIT_FILL;
        end
      end
      WAIT_FILL: begin
        if (fill_done) begin
          next_state = COMPARE; // Retry, now a hit
        end
      end
      RESPOND: begin
        if (rsp_ready) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= IDLE;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      state <= next_state;
      if (hit && cur_req.write) begin
        dirty_q[cur_index] <= 1'b1;
      end
      if (fill_load) begin
        valid_q[cur_index] <= 1'b1;
        dirty_q[cur_index] <= 1'b0; // Fresh line matches memory
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= arb_req;
    end
    if (hit) begin
      rsp.port  <= cur_req.port;
      rsp.write <= cur_req.write;
      rsp.data  <= cur_req.write ? cur_req.wdata : data_q[cur_index];
      if (cur_req.write) begin
        data_q[cur_index] <= cur_req.wdata;
      end
    end
    if (fill_load) begin
      tag_q[cur_index]  <= cur_tag;
      data_q[cur_index] <= fill_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/l3_req_arbiter.sv ====
/*
  Round-robin request arbiter
  Picks one of the L2 ports per cycle and holds it in a single output register
*/
`default_nettype none

module l3_req_arbiter (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [l3_cache_pkg::NUM_PORTS-1:0]   port_valid,
  input  l3_cache_pkg::l3_req_t                port_req [l3_cache_pkg::NUM_PORTS],
  output logic [l3_cache_pkg::NUM_PORTS-1:0]   port_ready,
  output logic                                 arb_valid,
  output l3_cache_pkg::l3_req_t                arb_req,
  input  logic                                 arb_ready
);

  import l3_cache_pkg::*;

  logic [PORT_W-1:0] last_port;   // Most recently granted port
  logic [PORT_W-1:0] grant_port;
  logic              grant_found;
  logic              can_accept;
  l3_req_t           grant_req;

  // Register empty or being drained this cycle
  assign can_accept = !arb_valid || arb_ready;

  // Search starts at the port after the last grant
  always_comb begin
    logic [PORT_W-1:0] cand;
    grant_found = 1'b0;
    grant_port  = last_port;
    for (int i = 1; i <= NUM_PORTS; i++) begin
      cand = last_port + PORT_W'(i);
      if (!grant_found && port_valid[cand]) begin
        grant_found = 1'b1;
        grant_port  = cand;
      end
    end
  end

  always_comb begin
    port_ready = '0;
    if (grant_found && can_accept) begin
      port_ready[grant_port] = 1'b1;
    end
  end

  // Stamp the winner's port number into its request
  always_comb begin
    grant_req      = port_req[grant_port];
    grant_req.port = grant_port;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      arb_valid <= 1'b0;
      last_port <= PORT_W'(NUM_PORTS - 1); // Port 0 wins first
    end else if (can_accept) begin
      arb_valid <= grant_found;
      if (grant_found) begin
        last_port <= grant_port;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_accept && grant_found) begin
      arb_req <= grant_req;
    end
  end

endmodule

`default_nettype wire

// ==== hw/l3_top.sv ====
/*
  L3 cache top level
  Arbiter, lookup stage and line fill between four L2 ports and main memory
*/
`default_nettype none

module l3_top (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [l3_cache_pkg::NUM_PORTS-1:0]   port_valid,
  input  l3_cache_pkg::l3_req_t                port_req [l3_cache_pkg::NUM_PORTS],
  output logic [l3_cache_pkg::NUM_PORTS-1:0]   port_ready,
  output logic                                 rsp_valid,
  output l3_cache_pkg::l3_rsp_t                rsp,
  input  logic                                 rsp_ready,
  output logic                                 mem_req_valid,
  output l3_cache_pkg::mem_req_t               mem_req,
  input  logic                                 mem_req_ready,
  input  logic                                 mem_rsp_valid,
  input  logic [l3_cache_pkg::DATA_W-1:0]      mem_rsp_data
);

  import l3_cache_pkg::*;

  // Arbiter to lookup
  logic    arb_valid;
  logic    arb_ready;
  l3_req_t arb_req;

  // Lookup to line fill
  logic              fill_valid;
  logic              fill_ready;
  logic              fill_victim_dirty;
  logic [ADDR_W-1:0] fill_victim_addr;
  logic [DATA_W-1:0] fill_victim_data;
  logic [ADDR_W-1:0] fill_addr;
  logic              fill_done;
  logic [DATA_W-1:0] fill_data;

  l3_req_arbiter arbiter_i (
    .clk        (clk),
    .reset      (reset),
    .port_valid (port_valid),
    .port_req   (port_req),
    .port_ready (port_ready),
    .arb_valid  (arb_valid),
    .arb_req    (arb_req),
    .arb_ready  (arb_ready)
  );

  l3_lookup lookup_i (
    .clk               (clk),
    .reset             (reset),
    .arb_valid         (arb_valid),
    .arb_req           (arb_req),
    .arb_ready         (arb_ready),
    .fill_valid        (fill_valid),
    .fill_ready        (fill_ready),
    .fill_victim_dirty (fill_victim_dirty),
    .fill_victim_addr  (fill_victim_addr),
    .fill_victim_data  (fill_victim_data),
    .fill_addr         (fill_addr),
    .fill_done         (fill_done),
    .fill_data         (fill_data),
    .rsp_valid         (rsp_valid),
    .rsp               (rsp),
    .rsp_ready         (rsp_ready)
  );

  l3_line_fill line_fill_i (
    .clk               (clk),
    .reset             (reset),
    .fill_valid        (fill_valid),
    .fill_victim_dirty (fill_victim_dirty),
    .fill_victim_addr  (fill_victim_addr),
    .fill_victim_data  (fill_victim_data),
    .fill_addr         (fill_addr),
    .fill_ready        (fill_ready),
    .fill_done         (fill_done),
    .fill_data         (fill_data),
    .mem_req_valid     (mem_req_valid),
    .mem_req           (mem_req),
    .mem_req_ready     (mem_req_ready),
    .mem_rsp_valid     (mem_rsp_valid),
    .mem_rsp_data      (mem_rsp_data)
  );

endmodule

`default_nettype wire

// ==== verilog.f ====
common/l3_cache_pkg.sv
hw/l3_req_arbiter.sv
hw/l3_cache/l3_lookup.sv
hw/l3_cache/l3_line_fill.sv
hw/l3_top.sv
bench/l3_top_chk.sv
bench/l3_top_tb.sv
